// ==== design/coarseHistogram.sv ====
`timescale 1ns/100ps
`include "histConfig.svh"

module coarseHistogram (
    input  logic              clk,
    input  logic              res,
    input  logic              eventValid,
    input  tdcPkg::timestampT timestamp,
    input  logic              acquiring,
    input  logic              readEn,
    input  histPkg::binIdxT   readIdx,
    input  logic              clearAll,
    output histPkg::countT    readCount
);
    import tdcPkg::*;
    import histPkg::*;

    localparam int NUM_BINS = 1 << `COARSE_BITS;

    countT               countRam [NUM_BINS];
    logic [NUM_BINS-1:0] binValid;      // lazy clear, one bit per bin

    coarseT eventBin;
    logic   accept;
    logic   forward;

    logic   s1Valid;
    coarseT s1Bin;
    countT  s1Count;
    logic   s1Seen;                     // bin already holds a count this frame
    countT  wrCount;

    assign eventBin = coarseOf(timestamp);
    assign accept   = eventValid && acquiring;

    // stage 2 result, first hit of a frame starts at one
    assign wrCount = s1Seen ? satInc(s1Count) : countT'(1);

    // write and read of the same bin in one edge
    assign forward = s1Valid && (s1Bin == eventBin);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
        end
    end

    // stage 1 read of the addressed bin
    always_ff @(posedge clk) begin
        s1Bin <= eventBin;
        if (forward) begin
            s1Count <= wrCount;         // take the value being written now
            s1Seen  <= 1'b1;
        end else begin
            s1Count <= countRam[eventBin];
            s1Seen  <= binValid[eventBin];
        end
    end

    // stage 2 write back
    always_ff @(posedge clk) begin
        if (s1Valid) begin
            countRam[s1Bin] <= wrCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid <= '0;
        end else if (clearAll) begin
            binValid <= '0;
        end else if (s1Valid) begin
            binValid[s1Bin] <= 1'b1;
        end
    end

    // sweep read port, stale bins read as zero
    always_ff @(posedge clk) begin
        if (readEn) begin
            readCount <= binValid[readIdx] ? countRam[readIdx] : '0;
        end
    end

    // the sweep must never overlap the acquisition window
    noScanDuringAcq: assert property (@(posedge clk) disable iff (!res)
        !(readEn && acquiring))
        else $error("coarseHistogram: readEn and acquiring high together");

endmodule

// ==== design/fineHistogram.sv ====
`timescale 1ns/100ps
`include "histConfig.svh"

module fineHistogram (
    input  logic              clk,
    input  logic              res,
    input  logic              eventValid,
    input  tdcPkg::timestampT timestamp,
    input  logic              acquiring,
    input  logic              readEn,
    input  histPkg::binIdxT   readIdx,
    input  logic              clearAll,
    input  histPkg::binIdxT   gateBin,
    input  logic              gateValid,
    output histPkg::countT    readCount
);
    import tdcPkg::*;
    import histPkg::*;

    localparam int NUM_BINS = 1 << `FINE_BITS;

    countT               countRam [NUM_BINS];
    logic [NUM_BINS-1:0] binValid;

    fineT   eventBin;
    logic   inGate;
    logic   accept;
    logic   forward;

    logic   s1Valid;
    fineT   s1Bin;
    countT  s1Count;
    logic   s1Seen;
    countT  wrCount;

    assign eventBin = fineOf(timestamp);

    // ungated until the combiner arms a coarse bin
    assign inGate = !gateValid || (coarseOf(timestamp) == gateBin);
    assign accept = eventValid && acquiring && inGate;

    assign wrCount = s1Seen ? satInc(s1Count) : countT'(1);
    assign forward = s1Valid && (s1Bin == eventBin);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= eventBin;
        if (forward) begin
            s1Count <= wrCount;         // back-to-back hit on one bin
            s1Seen  <= 1'b1;
        end else begin
            s1Count <= countRam[eventBin];
            s1Seen  <= binValid[eventBin];
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            countRam[s1Bin] <= wrCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid <= '0;
        end else if (clearAll) begin
            binValid <= '0;
        end else if (s1Valid) begin
            binValid[s1Bin] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (readEn) begin
            readCount <= binValid[readIdx] ? countRam[readIdx] : '0;
        end
    end

    // DRAIN has to empty the pipeline before the frame is cleared
    noWriteOnClear: assert property (@(posedge clk) disable iff (!res)
        clearAll |-> !s1Valid)
        else $error("fineHistogram: bin write in the clearAll cycle");

endmodule

// ==== design/histPkg.sv ====
`include "histConfig.svh"

package histPkg;

    typedef logic [`COUNT_WIDTH-1:0] countT;

    // coarse and fine fields are both 5 bits wide, one index type for both sweeps
    typedef logic [`COARSE_BITS-1:0] binIdxT;

    typedef enum logic [2:0] {
        ACQUIRE,
        DRAIN,
        SCAN,
        REPORT,
        CLEAR
    } combStateT;

    // count plus one, sticks at all ones
    function automatic countT satInc(countT c);
        return (c == '1) ? c : c + 1'b1;
    endfunction

endpackage

// ==== design/peakCombiner.sv ====
`timescale 1ns/100ps
`include "histConfig.svh"

module peakCombiner (
    input  logic            clk,
    input  logic            res,
    input  histPkg::countT  coarseCount,
    input  histPkg::countT  fineCount,
    output logic            acquiring,
    output logic            readEn,
    output histPkg::binIdxT readIdx,
    output logic            clearAll,
    output histPkg::binIdxT gateBin,
    output logic            gateValid,
    output logic            peakValid,
    output tdcPkg::coarseT  coarsePeak,
    output histPkg::countT  coarsePeakCount,
    output tdcPkg::fineT    finePeak,
    output histPkg::countT  finePeakCount,
    output logic            fineGated
);
    import tdcPkg::*;
    import histPkg::*;

    localparam int CYCLE_W      = $clog2(`FRAME_CYCLES);
    localparam int DRAIN_CYCLES = 2;

    combStateT          state;
    combStateT          nextState;
    logic [CYCLE_W-1:0] cycleCnt;

    logic   rdValid;                    // readCount of both builders is live
    binIdxT rdIdx;                      // bin that readCount belongs to

    coarseT bestCoarse;
    countT  bestCoarseCount;
    fineT   bestFine;
    countT  bestFineCount;
    coarseT newCoarse;
    countT  newCoarseCount;
    fineT   newFine;
    countT  newFineCount;

    always_comb begin
        nextState = state;
        case (state)
            ACQUIRE: if (cycleCnt == CYCLE_W'(`FRAME_CYCLES - 1)) nextState = DRAIN;
            DRAIN:   if (cycleCnt == CYCLE_W'(DRAIN_CYCLES - 1)) nextState = SCAN;
            SCAN:    if (readIdx == '1) nextState = REPORT;
            REPORT:  nextState = CLEAR;
            CLEAR:   nextState = ACQUIRE;
            default: nextState = CLEAR;
        endcase
    end

    // reset sits in CLEAR so the first edge opens the window
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= CLEAR;
            cycleCnt  <= '0;
            acquiring <= 1'b0;
            readEn    <= 1'b0;
            clearAll  <= 1'b0;
            readIdx   <= '0;
            rdValid   <= 1'b0;
        end else begin
            state     <= nextState;
            cycleCnt  <= (nextState != state) ? '0 : cycleCnt + 1'b1;
            acquiring <= (nextState == ACQUIRE);
            readEn    <= (nextState == SCAN);
            clearAll  <= (nextState == CLEAR);
            if (readEn) begin
                readIdx <= readIdx + 1'b1;      // wraps back to 0 after the sweep
            end
            rdValid   <= readEn;
        end
    end

    always_ff @(posedge clk) begin
        rdIdx <= readIdx;
    end

    // strict compare, ascending sweep keeps the lowest index on a tie
    always_comb begin
        newCoarse      = bestCoarse;
        newCoarseCount = bestCoarseCount;
        newFine        = bestFine;
        newFineCount   = bestFineCount;
        if (rdValid && (coarseCount > bestCoarseCount)) begin
            newCoarse      = rdIdx;
            newCoarseCount = coarseCount;
        end
        if (rdValid && (fineCount > bestFineCount)) begin
            newFine      = rdIdx;
            newFineCount = fineCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bestCoarse      <= '0;
            bestCoarseCount <= '0;
            bestFine        <= '0;
            bestFineCount   <= '0;
        end else if (state == DRAIN) begin
            bestCoarse      <= '0;          // empty histogram reports bin 0
            bestCoarseCount <= '0;
            bestFine        <= '0;
            bestFineCount   <= '0;
        end else if (rdValid) begin
            bestCoarse      <= newCoarse;
            bestCoarseCount <= newCoarseCount;
            bestFine        <= newFine;
            bestFineCount   <= newFineCount;
        end
    end

    // last bin returns during REPORT, so results take the merged values
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid       <= 1'b0;
            coarsePeak      <= '0;
            coarsePeakCount <= '0;
            finePeak        <= '0;
            finePeakCount   <= '0;
            fineGated       <= 1'b0;
            gateBin         <= '0;
            gateValid       <= 1'b0;
        end else begin
            peakValid <= (state == REPORT);
            if (state == REPORT) begin
                coarsePeak      <= newCoarse;
                coarsePeakCount <= newCoarseCount;
                finePeak        <= newFine;
                finePeakCount   <= newFineCount;
                fineGated       <= gateValid;   // gate that was in force this frame
                gateBin         <= newCoarse;
                gateValid       <= (newCoarseCount != '0);
            end
        end
    end

    peakOnePulse: assert property (@(posedge clk) disable iff (!res)
        peakValid |=> !peakValid)
        else $error("peakCombiner: peakValid longer than one cycle");

    readOnlyInScan: assert property (@(posedge clk) disable iff (!res)
        readEn |-> (state == SCAN))
        else $error("peakCombiner: readEn outside SCAN");

endmodule

// ==== design/tdcPkg.sv ====
`include "histConfig.svh"

package tdcPkg;

    // raw TDC word
    typedef logic [`TS_WIDTH-1:0] timestampT;

    // coarse field selects the coarse bin
    typedef logic [`COARSE_BITS-1:0] coarseT;

    // fine field, binned only inside the gate
    typedef logic [`FINE_BITS-1:0] fineT;

    // upper bits of a timestamp
    function automatic coarseT coarseOf(timestampT ts);
        return ts[`TS_WIDTH-1 -: `COARSE_BITS];
    endfunction

    // lower bits of a timestamp
    function automatic fineT fineOf(timestampT ts);
        return ts[`FINE_BITS-1:0];
    endfunction

endpackage

// ==== design/tofHistogramTop.sv ====
`timescale 1ns/100ps

module tofHistogramTop (
    input  logic              clk,
    input  logic              res,
    input  logic              eventValid,
    input  tdcPkg::timestampT timestamp,
    output logic              peakValid,
    output tdcPkg::coarseT    coarsePeak,
    output histPkg::countT    coarsePeakCount,
    output tdcPkg::fineT      finePeak,
    output histPkg::countT    finePeakCount,
    output logic              fineGated,
    output logic              acquiring
);
    import histPkg::*;

    logic   readEn;
    binIdxT readIdx;
    logic   clearAll;
    binIdxT gateBin;
    logic   gateValid;
    countT  coarseCount;
    countT  fineCount;

    coarseHistogram u_coarseHistogram (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .timestamp  (timestamp),
        .acquiring  (acquiring),
        .readEn     (readEn),
        .readIdx    (readIdx),
        .clearAll   (clearAll),
        .readCount  (coarseCount)
    );

    // refines last frame's coarse peak
    fineHistogram u_fineHistogram (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .timestamp  (timestamp),
        .acquiring  (acquiring),
        .readEn     (readEn),
        .readIdx    (readIdx),
        .clearAll   (clearAll),
        .gateBin    (gateBin),
        .gateValid  (gateValid),
        .readCount  (fineCount)
    );

    peakCombiner u_peakCombiner (
        .clk             (clk),
        .res             (res),
        .coarseCount     (coarseCount),
        .fineCount       (fineCount),
        .acquiring       (acquiring),
        .readEn          (readEn),
        .readIdx         (readIdx),
        .clearAll        (clearAll),
        .gateBin         (gateBin),
        .gateValid       (gateValid),
        .peakValid       (peakValid),
        .coarsePeak      (coarsePeak),
        .coarsePeakCount (coarsePeakCount),
        .finePeak        (finePeak),
        .finePeakCount   (finePeakCount),
        .fineGated       (fineGated)
    );

endmodule

// ==== files.f ====
+incdir+include
design/tdcPkg.sv
design/histPkg.sv
design/coarseHistogram.sv
design/fineHistogram.sv
design/peakCombiner.sv
design/tofHistogramTop.sv
tb/tofHistogramTb.sv

// ==== include/histConfig.svh ====
`ifndef HIST_CONFIG_SVH
`define HIST_CONFIG_SVH

// timestamp split into coarse (upper) and fine (lower) fields
`define TS_WIDTH     10
`define COARSE_BITS  5
`define FINE_BITS    (`TS_WIDTH - `COARSE_BITS)

`define COUNT_WIDTH  8     // saturates at 255

// acquisition window per frame, in clocks
`define FRAME_CYCLES 200

`endif

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tofHistogramTb -o tofHistogramSim

./obj_dir/tofHistogramSim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== tb/tofHistogramTb.sv ====
`timescale 1ns/100ps
`include "histConfig.svh"

module tofHistogramTb;

    localparam int SLOTS      = `FRAME_CYCLES + 36;    // one full frame period in clocks
    localparam int LAST_SLOT  = SLOTS - 3;             // stimulus ends before peakValid shows
    localparam int MAX_FRAMES = 16;

    logic                    clk;
    logic                    res;
    logic                    eventValid;
    logic [`TS_WIDTH-1:0]    timestamp;
    logic                    peakValid;
    logic [`COARSE_BITS-1:0] coarsePeak;
    logic [`COUNT_WIDTH-1:0] coarsePeakCount;
    logic [`FINE_BITS-1:0]   finePeak;
    logic [`COUNT_WIDTH-1:0] finePeakCount;
    logic                    fineGated;
    logic                    acquiring;

    // slot offsets per frame relative to the rise of acquiring
    logic                 slotUsed [MAX_FRAMES][SLOTS];
    logic [`TS_WIDTH-1:0] slotTs   [MAX_FRAMES][SLOTS];
    int                   frameId  [MAX_FRAMES];
    int                   padded   [MAX_FRAMES];
    int                   lastSlot [MAX_FRAMES];
    int                   expVal   [MAX_FRAMES][5];    // cPeak cCount fPeak fCount gated
    logic                 haveExp  [MAX_FRAMES];
    int                   numFrames = 0;

    int seed        = 32730;
    int errorCount  = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int cycleCount  = 0;
    int cycleLimit  = 1000000;                         // replaced once the vectors are read

    tofHistogramTop u_tofHistogramTop (
        .clk             (clk),
        .res             (res),
        .eventValid      (eventValid),
        .timestamp       (timestamp),
        .peakValid       (peakValid),
        .coarsePeak      (coarsePeak),
        .coarsePeakCount (coarsePeakCount),
        .finePeak        (finePeak),
        .finePeakCount   (finePeakCount),
        .fineGated       (fineGated),
        .acquiring       (acquiring)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the frames did not complete", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    // filler word with its coarse field in the minor bins 24..31
    function automatic logic [`TS_WIDTH-1:0] padTimestamp(input int r);
        logic [`COARSE_BITS-1:0] c;
        logic [`FINE_BITS-1:0]   fn;
        c  = {2'b11, r[2:0]};
        fn = r[`FINE_BITS+2:3];
        return {c, fn};
    endfunction

    task automatic readVectors();
        int    fd;
        int    code;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    f;
        int    s;
        string tag;
        string rest;
        fd = $fopen("tb/tofHistogram_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file tb/tofHistogram_vectors.txt");
            errorCount++;
            return;
        end
        f = -1;
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "F") begin
                code = $fscanf(fd, "%d %d", a, b);
                if (numFrames == MAX_FRAMES) begin
                    $display("vector file holds more than %0d frames", MAX_FRAMES);
                    errorCount++;
                    $fclose(fd);
                    return;
                end
                f = numFrames;
                numFrames++;
                frameId[f]  = a;
                padded[f]   = b;
                lastSlot[f] = `FRAME_CYCLES - 1;
                haveExp[f]  = 1'b0;
                for (s = 0; s < SLOTS; s++) begin
                    slotUsed[f][s] = 1'b0;
                end
            end else if (tag == "E" || tag == "B") begin
                if (tag == "E") begin
                    code = $fscanf(fd, "%d %d", a, c);
                    b = 1;
                end else begin
                    code = $fscanf(fd, "%d %d %d", a, b, c);   // burst of b events
                end
                if (f < 0 || a < 0 || b < 1 || a + b - 1 > LAST_SLOT) begin
                    $display("vector file has an event line outside a frame or its slots");
                    errorCount++;
                end else begin
                    for (s = a; s < a + b; s++) begin
                        slotUsed[f][s] = 1'b1;
                        slotTs[f][s]   = c[`TS_WIDTH-1:0];
                    end
                    if (a + b - 1 > lastSlot[f]) begin
                        lastSlot[f] = a + b - 1;
                    end
                end
            end else if (tag == "X") begin
                code = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
                if (f < 0) begin
                    $display("vector file has a result line before the first frame");
                    errorCount++;
                end else begin
                    expVal[f][0] = a;
                    expVal[f][1] = b;
                    expVal[f][2] = c;
                    expVal[f][3] = d;
                    expVal[f][4] = e;
                    haveExp[f]   = 1'b1;
                end
            end else begin
                $display("vector file has a line with the unknown tag %s", tag);
                errorCount++;
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    task automatic runFrame(input int f);
        int   s;
        int   waitCycles;
        int   errorsBefore;
        logic expAcq;
        errorsBefore = errorCount;
        while (acquiring) @(negedge clk);
        while (!acquiring) @(negedge clk);             // offset 0 of this frame
        for (s = 0; s <= lastSlot[f]; s++) begin
            if (s > 0) begin
                @(negedge clk);
            end
            expAcq = (s < `FRAME_CYCLES);              // window is exactly FRAME_CYCLES long
            if (acquiring != expAcq) begin
                $display("FAIL t=%0t acquiring got %0d expected %0d",
                         $time, acquiring, expAcq);
                errorCount++;
            end
            if (slotUsed[f][s]) begin
                eventValid = 1'b1;
                timestamp  = slotTs[f][s];
            end else begin
                timestamp  = padTimestamp($random(seed));
                eventValid = (padded[f] != 0) && (s < `FRAME_CYCLES);
            end
        end
        @(negedge clk);
        eventValid = 1'b0;
        waitCycles = 0;
        while (!peakValid && waitCycles < SLOTS) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!peakValid) begin
            $display("frame %0d: peakValid did not arrive after the window", frameId[f]);
            errorCount++;
        end else begin
            if (int'(coarsePeak) != expVal[f][0]) begin
                $display("FAIL t=%0t coarsePeak got %0d expected %0d",
                         $time, coarsePeak, expVal[f][0]);
                errorCount++;
            end
            if (int'(coarsePeakCount) != expVal[f][1]) begin
                $display("FAIL t=%0t coarsePeakCount got %0d expected %0d",
                         $time, coarsePeakCount, expVal[f][1]);
                errorCount++;
            end
            if (int'(finePeak) != expVal[f][2]) begin
                $display("FAIL t=%0t finePeak got %0d expected %0d",
                         $time, finePeak, expVal[f][2]);
                errorCount++;
            end
            if (int'(finePeakCount) != expVal[f][3]) begin
                $display("FAIL t=%0t finePeakCount got %0d expected %0d",
                         $time, finePeakCount, expVal[f][3]);
                errorCount++;
            end
            if (int'(fineGated) != expVal[f][4]) begin
                $display("FAIL t=%0t fineGated got %0d expected %0d",
                         $time, fineGated, expVal[f][4]);
                errorCount++;
            end
        end
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("frame %0d: pass", frameId[f]);
        end else begin
            testsFailed++;
            $display("frame %0d: fail", frameId[f]);
        end
    endtask

    initial begin
        int i;
        res        = 1'b0;
        eventValid = 1'b0;
        timestamp  = '0;
        readVectors();
        if (numFrames == 0) begin
            $display("vector file holds no frames");
            errorCount++;
        end
        cycleLimit = (numFrames + 2) * SLOTS;
        repeat (3) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        for (i = 0; i < numFrames; i++) begin
            if (!haveExp[i]) begin
                $display("frame %0d: no expected result line in the vector file", frameId[i]);
                errorCount++;
                testsFailed++;
            end else begin
                runFrame(i);
            end
        end
        $display("frames run %0d, passed %0d, failed %0d, errors %0d",
                 testsPassed + testsFailed, testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/tofHistogram_vectors.txt ====
# F frame pad : pad 1 fills free window slots with valid events in coarse bins 24..31
# E offset ts : one event, offset counted in clocks from the rise of acquiring
# B offset count ts : burst of back-to-back events to one timestamp
# X cPeak cCount fPeak fCount gated : expected result of the frame
# ts = coarse * 32 + fine, offsets 200 and above fall outside the window
F 1 0
B 0 10 163
B 20 4 167
B 40 12 308
X 5 14 20 12 0
# gated on coarse 5, coarse 12 and the filler stay out of the fine histogram
F 2 1
B 10 60 171
B 80 8 163
B 100 20 386
X 5 68 11 60 1
# ties in both histograms, lower index wins
F 3 0
B 0 12 448
B 30 12 193
B 60 5 178
B 70 5 169
X 6 12 9 5 1
# window full of one bin, the 200-cycle window keeps it below the saturation point
F 4 0
B 0 230 196
X 6 200 4 200 1
# late burst to coarse 20 must not count here or in frame 6
F 5 0
B 5 7 94
E 50 205
E 51 205
E 120 205
B 205 20 645
X 2 7 13 3 1
F 6 0
X 0 0 0 0 1
# gate dropped after the empty frame
F 7 0
B 0 5 97
B 20 4 345
B 30 4 377
X 3 5 25 8 0
